//--- dv/m26_rx_tb.sv
`timescale 1ns/1ps

module m26_rx_tb import m26_rx_pkg::*; ();

    localparam int N_FRAMES      = 19;
    localparam int MAX_FRAME_CYC = MARKER_LEN + WORD_W * (MAX_DATA_LEN + 6) + 8;
    localparam int MARGIN_CYC    = 2000;

    logic       CLK_RX;
    logic       RST;
    logic       mkd;
    logic [1:0] data_rx;
    logic [7:0] bus_add;
    logic [7:0] bus_data_in;
    logic       bus_wr;
    logic       bus_rd;
    logic [7:0] bus_data_out;
    rx_record_t out_rec;
    logic       out_valid;
    logic       out_ready;
    logic       lost_error;

    integer     seed = 36;
    integer     rdy_seed = 36;
    int         errors = 0;
    int         rdy_mode = 0;    // 0 ready high, 1 ready low, 2 random
    bit         model_en = 1'b0;
    bit         model_hold = 1'b0;   // ready held low, FIFO fills from empty
    int         held = 0;
    int         lost_exp = 0;
    int         lost_sat;
    rx_record_t exp_q0[$];
    rx_record_t exp_q1[$];
    rx_record_t exp_rec;
    logic [7:0] rd_val;

    m26_rx_top m26_rx_top_i (.*);

    initial CLK_RX = 1'b0;
    always #50 CLK_RX = ~CLK_RX;

    task automatic next_cycle();
        @(posedge CLK_RX);
        #1;
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] val);
        bus_add     = addr;
        bus_data_in = val;
        bus_wr      = 1'b1;
        next_cycle();
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [7:0] val);
        bus_add = addr;
        bus_rd  = 1'b1;
        next_cycle();
        bus_rd = 1'b0;
        val    = bus_data_out;   // registered on the read edge
    endtask

    task automatic expect_word(input bit ch, input logic [15:0] w, input bit first);
        rx_record_t r;
        if (!model_en)
            return;
        if (model_hold) begin
            if (held == FIFO_DEPTH) begin
                lost_exp++;
                return;
            end
            held++;
        end
        r = {HEADER_ID, STREAM_ID, 2'b00, ch, first, w};   // header, ident, zero, channel, start
        if (ch)
            exp_q1.push_back(r);
        else
            exp_q0.push_back(r);
    endtask

    // header, two frame counters, length, then data and trailers unless aborted
    task automatic build_words(input int len, ref logic [15:0] w[$]);
        w = {};
        repeat (3) w.push_back(16'($random(seed)));
        w.push_back(len[15:0]);
        if (len <= MAX_DATA_LEN)
            repeat (len + 2) w.push_back(16'($random(seed)));
    endtask

    task automatic send_frame(input int len0, input int len1);
        logic [15:0] w0[$];
        logic [15:0] w1[$];
        int          n;
        build_words(len0, w0);
        build_words(len1, w1);
        n = (w0.size() > w1.size()) ? w0.size() : w1.size();
        for (int k = 0; k < n; k++) begin   // lane 1 skew puts its word k after lane 0 word k
            if (k < w0.size())
                expect_word(1'b0, w0[k], k == 0);
            if (k < w1.size())
                expect_word(1'b1, w1[k], 1'b0);
        end
        mkd = 1'b1;
        repeat (MARKER_LEN) next_cycle();
        mkd = 1'b0;
        for (int k = 0; k < n; k++) begin
            for (int b = WORD_W - 1; b >= 0; b--) begin
                data_rx[0] = (k < w0.size()) ? w0[k][b] : 1'b0;
                data_rx[1] = (k < w1.size()) ? w1[k][b] : 1'b0;
                next_cycle();
            end
        end
        data_rx = 2'b00;
        repeat (3'($random(seed))) next_cycle();
    endtask

    task automatic wait_drain();
        while (exp_q0.size() != 0 || exp_q1.size() != 0)
            next_cycle();
    endtask

    initial begin
        out_ready = 1'b0;
        forever begin
            next_cycle();
            case (rdy_mode)
                0:       out_ready = 1'b1;
                1:       out_ready = 1'b0;
                default: out_ready = 1'($random(rdy_seed));
            endcase
        end
    end

    // a transfer takes place on the following rising edge
    initial forever begin
        @(negedge CLK_RX);
        if (!RST && out_valid && out_ready) begin
            if (out_rec.channel ? exp_q1.size() == 0 : exp_q0.size() == 0) begin
                $display("record %h arrived on channel %0d with none expected",
                         out_rec, out_rec.channel);
                errors++;
            end else begin
                exp_rec = out_rec.channel ? exp_q1.pop_front() : exp_q0.pop_front();
                if (out_rec !== exp_rec) begin
                    $display("Error: out_rec got %h expected %h", out_rec, exp_rec);
                    errors++;
                end
            end
        end
    end

    initial begin
        repeat (N_FRAMES * MAX_FRAME_CYC + MARGIN_CYC) @(posedge CLK_RX);
        $display("watchdog expired, records still pending: %0d", exp_q0.size() + exp_q1.size());
        $display("errors: %0d", errors + 1);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        RST         = 1'b1;
        mkd         = 1'b0;
        data_rx     = 2'b00;
        bus_add     = 8'h00;
        bus_data_in = 8'h00;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        repeat (8) @(posedge CLK_RX);
        #1;
        RST = 1'b0;
        next_cycle();

        bus_write(ADDR_ENABLE, 8'h01);
        model_en = 1'b1;
        send_frame(14, 3);    // lane 0 aborts, next frame must be whole
        send_frame(0, 15);
        repeat (4) send_frame($random(seed) & 15, $random(seed) & 15);
        wait_drain();
        rdy_mode = 2;
        repeat (6) send_frame($random(seed) & 15, $random(seed) & 15);
        wait_drain();
        rdy_mode = 0;
        bus_read(ADDR_LOST, rd_val);
        if (rd_val !== 8'h00) begin
            $display("Error: bus_data_out (ADDR_LOST) got %h expected %h", rd_val, 8'h00);
            errors++;
        end

        bus_write(ADDR_ENABLE, 8'h00);
        bus_read(ADDR_ENABLE, rd_val);
        if (rd_val !== 8'h00) begin
            $display("Error: bus_data_out (ADDR_ENABLE) got %h expected %h", rd_val, 8'h00);
            errors++;
        end
        model_en = 1'b0;
        repeat (3) send_frame($random(seed) & 15, $random(seed) & 15);
        repeat (10) next_cycle();
        bus_read(ADDR_LOST, rd_val);
        if (out_valid !== 1'b0) begin
            $display("records came out while enable was low");
            errors++;
        end
        if (rd_val !== 8'h00) begin
            $display("Error: bus_data_out (ADDR_LOST) got %h expected %h", rd_val, 8'h00);
            errors++;
        end

        bus_write(ADDR_ENABLE, 8'h01);
        bus_read(ADDR_ENABLE, rd_val);
        if (rd_val !== 8'h01) begin
            $display("Error: bus_data_out (ADDR_ENABLE) got %h expected %h", rd_val, 8'h01);
            errors++;
        end
        model_en   = 1'b1;
        rdy_mode   = 1;
        model_hold = 1'b1;
        repeat (3) send_frame($random(seed) & 15, $random(seed) & 15);
        repeat (10) next_cycle();
        lost_sat = (lost_exp > 255) ? 255 : lost_exp;
        bus_read(ADDR_LOST, rd_val);
        if (rd_val !== lost_sat[7:0]) begin
            $display("Error: bus_data_out (ADDR_LOST) got %h expected %h",
                     rd_val, lost_sat[7:0]);
            errors++;
        end
        if (lost_error !== 1'b1) begin
            $display("lost_error stayed low after records were dropped");
            errors++;
        end
        model_hold = 1'b0;
        rdy_mode   = 0;
        wait_drain();
        repeat (10) next_cycle();
        if (out_valid !== 1'b0) begin
            $display("more records came out than the FIFO could hold");
            errors++;
        end

        bus_read(ADDR_RESET, rd_val);
        if (rd_val !== VERSION) begin
            $display("Error: bus_data_out (ADDR_RESET) got %h expected %h", rd_val, VERSION);
            errors++;
        end
        bus_read(8'h07, rd_val);
        if (rd_val !== 8'h00) begin
            $display("Error: bus_data_out (address 07) got %h expected %h", rd_val, 8'h00);
            errors++;
        end
        rdy_mode = 1;
        send_frame(2, 2);     // leave records in the FIFO for the soft reset
        bus_write(ADDR_RESET, 8'h00);
        repeat (2) next_cycle();
        exp_q0   = {};
        exp_q1   = {};
        model_en = 1'b0;
        if (out_valid !== 1'b0 || lost_error !== 1'b0) begin
            $display("out_valid or lost_error still high after soft reset");
            errors++;
        end
        rdy_mode = 0;
        bus_read(ADDR_ENABLE, rd_val);
        if (rd_val !== 8'h00) begin
            $display("Error: bus_data_out (ADDR_ENABLE) got %h expected %h", rd_val, 8'h00);
            errors++;
        end
        bus_read(ADDR_LOST, rd_val);
        if (rd_val !== 8'h00) begin
            $display("Error: bus_data_out (ADDR_LOST) got %h expected %h", rd_val, 8'h00);
            errors++;
        end
        repeat (10) next_cycle();

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- hdl/m26_rx_ch.sv
`timescale 1ns/1ps

module m26_rx_ch import m26_rx_pkg::*; (
    input  logic              CLK_RX,
    input  logic              RST,
    input  logic              mkd,
    input  logic              bit_in,
    output logic              word_valid,
    output logic [WORD_W-1:0] word,
    output logic              word_first
);

    ch_state_e                          state;
    logic [$clog2(WORD_W)-1:0]          bit_cnt;
    logic [$clog2(MARKER_LEN)-1:0]      mkd_cnt;
    logic [$clog2(MAX_DATA_LEN+1)-1:0]  data_cnt;   // data words still to come
    logic [WORD_W-2:0]                  shreg;      // msb first
    logic [WORD_W-1:0]                  new_word;
    logic                               word_end;

    assign new_word = {shreg, bit_in};
    assign word_end = (state != IDLE) && (bit_cnt == WORD_W - 1);

    // first header bit is sampled on the cycle the state shows HEADER
    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            mkd_cnt    <= '0;
            data_cnt   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_end;   // one cycle after the 16th sample
            if (state == IDLE) begin
                bit_cnt <= '0;
                if (!mkd) begin
                    mkd_cnt <= '0;
                end else if (mkd_cnt == MARKER_LEN - 1) begin
                    mkd_cnt <= '0;
                    state   <= HEADER;
                end else begin
                    mkd_cnt <= mkd_cnt + 1'b1;
                end
            end else begin
                bit_cnt <= word_end ? '0 : bit_cnt + 1'b1;
                if (word_end) begin
                    case (state)
                        HEADER:   state <= FCNT_HI;
                        FCNT_HI:  state <= FCNT_LO;
                        FCNT_LO:  state <= LENGTH;
                        LENGTH: begin
                            if (new_word > MAX_DATA_LEN) begin
                                state <= IDLE;   // abort, length word already out
                            end else if (new_word == '0) begin
                                state <= TRAIL_HI;
                            end else begin
                                data_cnt <= new_word[$bits(data_cnt)-1:0];
                                state    <= DATA;
                            end
                        end
                        DATA: begin
                            data_cnt <= data_cnt - 1'b1;
                            if (data_cnt == 1)
                                state <= TRAIL_HI;
                        end
                        TRAIL_HI: state <= TRAIL_LO;
                        default:  state <= IDLE;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK_RX) begin
        shreg <= new_word[WORD_W-2:0];
        if (word_end) begin
            word       <= new_word;
            word_first <= (state == HEADER);
        end
    end

    // a word seen back in IDLE ends an aborted or a complete frame
    a_idle_word_ends_frame: assert property (@(posedge CLK_RX) disable iff (RST)
        word_valid && state == IDLE |-> $past(state) == LENGTH || $past(state) == TRAIL_LO);

endmodule

//--- hdl/m26_rx_core.sv
`timescale 1ns/1ps

module m26_rx_core import m26_rx_pkg::*; (
    input  logic       CLK_RX,
    input  logic       RST,
    input  logic       soft_rst,
    input  logic       enable,
    input  logic       mkd,
    input  logic [1:0] data_rx,
    input  logic       out_ready,
    output logic       out_valid,
    output rx_record_t out_rec,
    output logic [7:0] lost_cnt
);

    logic                   rst_i;
    logic [LANE1_DELAY:0]   mkd_dly;     // [0] feeds channel 0, top bit channel 1
    logic [LANE1_DELAY:0]   lane1_dly;
    logic                   lane0_q;
    logic [1:0]             wv;
    logic [WORD_W-1:0]      word0;
    logic [WORD_W-1:0]      word1;
    logic                   first0;
    logic                   push;
    logic                   full;
    rx_record_t             push_rec;

    assign rst_i = RST | soft_rst;

    always_ff @(posedge CLK_RX) begin
        if (rst_i)
            mkd_dly <= '0;
        else
            mkd_dly <= {mkd_dly[LANE1_DELAY-1:0], mkd};
    end

    always_ff @(posedge CLK_RX) begin
        lane0_q   <= data_rx[0];
        lane1_dly <= {lane1_dly[LANE1_DELAY-1:0], data_rx[1]};
    end

    m26_rx_ch ch0_i (
        .CLK_RX     (CLK_RX),
        .RST        (rst_i),
        .mkd        (mkd_dly[0]),
        .bit_in     (lane0_q),
        .word_valid (wv[0]),
        .word       (word0),
        .word_first (first0)
    );

    m26_rx_ch ch1_i (
        .CLK_RX     (CLK_RX),
        .RST        (rst_i),
        .mkd        (mkd_dly[LANE1_DELAY]),
        .bit_in     (lane1_dly[LANE1_DELAY]),
        .word_valid (wv[1]),
        .word       (word1),
        .word_first ()                 // frame start only marked on lane 0
    );

    assign push = (|wv) && enable;

    always_comb begin
        push_rec             = '0;
        push_rec.header      = HEADER_ID;
        push_rec.ident       = STREAM_ID;
        push_rec.channel     = !wv[0];    // strobes never overlap
        push_rec.frame_start = wv[0] && first0;
        push_rec.data        = wv[0] ? word0 : word1;
    end

    // dropped pushes, saturating
    always_ff @(posedge CLK_RX) begin
        if (rst_i)
            lost_cnt <= '0;
        else if (push && full && lost_cnt != 8'hff)
            lost_cnt <= lost_cnt + 1'b1;
    end

    m26_rx_fifo fifo_i (
        .CLK_RX    (CLK_RX),
        .RST       (rst_i),
        .push      (push),
        .push_rec  (push_rec),
        .out_ready (out_ready),
        .full      (full),
        .out_valid (out_valid),
        .out_rec   (out_rec)
    );

    a_strobes_apart: assert property (@(posedge CLK_RX) disable iff (rst_i)
        !(wv[0] && wv[1]));

endmodule

//--- hdl/m26_rx_fifo.sv
`timescale 1ns/1ps

module m26_rx_fifo import m26_rx_pkg::*; (
    input  logic       CLK_RX,
    input  logic       RST,
    input  logic       push,
    input  rx_record_t push_rec,
    input  logic       out_ready,
    output logic       full,
    output logic       out_valid,
    output rx_record_t out_rec
);

    rx_record_t         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;    // occupancy
    logic               do_push;
    logic               do_pop;

    assign full      = (count == FIFO_DEPTH);
    assign out_valid = (count != '0);
    assign out_rec   = mem[rd_ptr];   // head word falls through
    assign do_push   = push && !full;
    assign do_pop    = out_valid && out_ready;

    always_ff @(posedge CLK_RX) begin
        if (do_push)
            mem[wr_ptr] <= push_rec;
    end

    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at FIFO_DEPTH
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge CLK_RX) disable iff (RST)
        count <= FIFO_DEPTH);

endmodule

//--- hdl/m26_rx_pkg.sv
package m26_rx_pkg;

    localparam int WORD_W       = 16;     // bits per lane word
    localparam int MAX_DATA_LEN = 12;     // longer frames are aborted after the length word
    localparam int MARKER_LEN   = 4;      // marker high cycles that announce a frame
    localparam int LANE1_DELAY  = 4;      // lane 1 skew, keeps word strobes apart
    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_AW      = 4;

    localparam logic [7:0] VERSION   = 8'd1;
    localparam logic [7:0] HEADER_ID = 8'h20;
    localparam logic [3:0] STREAM_ID = 4'h3;

    // one output record, 32 bits
    typedef struct packed {
        logic [7:0]        header;
        logic [3:0]        ident;
        logic [1:0]        zero;
        logic              channel;       // index of the lane the word came from
        logic              frame_start;   // header word of channel 0
        logic [WORD_W-1:0] data;
    } rx_record_t;

    typedef enum logic [7:0] {
        ADDR_RESET  = 8'd0,               // reads version, write is a soft reset
        ADDR_ENABLE = 8'd2,
        ADDR_LOST   = 8'd3
    } reg_addr_e;

    // frame order on each lane
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        FCNT_HI,
        FCNT_LO,
        LENGTH,
        DATA,
        TRAIL_HI,
        TRAIL_LO
    } ch_state_e;

endpackage

//--- hdl/m26_rx_regs.sv
`timescale 1ns/1ps

module m26_rx_regs import m26_rx_pkg::*; (
    input  logic       CLK_RX,
    input  logic       RST,
    input  logic [7:0] bus_add,
    input  logic [7:0] bus_data_in,
    input  logic       bus_wr,
    input  logic       bus_rd,
    input  logic [7:0] lost_cnt,
    output logic [7:0] bus_data_out,
    output logic       enable,
    output logic       soft_rst,
    output logic       lost_error
);

    logic wr_reset;

    assign wr_reset   = bus_wr && (bus_add == ADDR_RESET);
    assign lost_error = (lost_cnt != '0);

    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            soft_rst <= 1'b0;
            enable   <= 1'b0;
        end else begin
            soft_rst <= wr_reset;          // pulse on the cycle after the write
            if (wr_reset)
                enable <= 1'b0;
            else if (bus_wr && bus_add == ADDR_ENABLE)
                enable <= bus_data_in[0];
        end
    end

    // read data held until the next read
    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            bus_data_out <= '0;
        end else if (bus_rd) begin
            case (bus_add)
                ADDR_RESET:  bus_data_out <= VERSION;
                ADDR_ENABLE: bus_data_out <= {7'b0, enable};
                ADDR_LOST:   bus_data_out <= lost_cnt;
                default:     bus_data_out <= '0;
            endcase
        end
    end

endmodule

//--- hdl/m26_rx_top.sv
`timescale 1ns/1ps

module m26_rx_top import m26_rx_pkg::*; (
    input  logic       CLK_RX,
    input  logic       RST,
    input  logic       mkd,
    input  logic [1:0] data_rx,
    input  logic [7:0] bus_add,
    input  logic [7:0] bus_data_in,
    input  logic       bus_wr,
    input  logic       bus_rd,
    output logic [7:0] bus_data_out,
    output rx_record_t out_rec,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       lost_error
);

    logic       soft_rst;
    logic       enable;
    logic [7:0] lost_cnt;

    m26_rx_regs regs_i (
        .CLK_RX       (CLK_RX),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .lost_cnt     (lost_cnt),
        .bus_data_out (bus_data_out),
        .enable       (enable),
        .soft_rst     (soft_rst),
        .lost_error   (lost_error)
    );

    m26_rx_core core_i (
        .CLK_RX    (CLK_RX),
        .RST       (RST),
        .soft_rst  (soft_rst),
        .enable    (enable),
        .mkd       (mkd),
        .data_rx   (data_rx),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_rec   (out_rec),
        .lost_cnt  (lost_cnt)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# compile and run the m26_rx testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module m26_rx_tb -Mdir obj_dir; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vm26_rx_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- tb.f
hdl/m26_rx_pkg.sv
hdl/m26_rx_ch.sv
hdl/m26_rx_fifo.sv
hdl/m26_rx_core.sv
hdl/m26_rx_regs.sv
hdl/m26_rx_top.sv
dv/m26_rx_tb.sv
